// ==== dv/pix_filter_model.svh ====
// reference model for the pixel filter testbench, one whole line at a time
// included inside the testbench module after the img_pkg import

`ifndef PIX_FILTER_MODEL_SVH
`define PIX_FILTER_MODEL_SVH

`include "img_params.svh"

`define MODEL_MAX_PIX 64     // pixels per line, two per beat
`define TB_WAIT_LIMIT 2000   // cycles before a wait gives up

rgb_t      line_px [0:`MODEL_MAX_PIX-1];   // line currently being sent
pix_beat_t exp_q [$];                      // expected output beats, in order

function automatic chan_t clamp_ch(int v);
    if (v < 0) begin
        return chan_t'(0);
    end
    if (v > `IMG_PIX_MAX) begin
        return chan_t'(`IMG_PIX_MAX);
    end
    return chan_t'(v);
endfunction

function automatic int gray_ref(rgb_t p);
    return (int'(p.red) + int'(p.green) + int'(p.blue)) / 3;
endfunction

function automatic rgb_t point_ref(rgb_t p, op_e o, op_arg_u a);
    int   g;
    int   amt;
    rgb_t res;
    g   = gray_ref(p);
    amt = int'(a.bright.amount);
    if (a.bright.darken) begin
        amt = -amt;
    end
    res = p;
    if (o == OP_BRIGHT) begin
        res.red   = clamp_ch(int'(p.red) + amt);
        res.green = clamp_ch(int'(p.green) + amt);
        res.blue  = clamp_ch(int'(p.blue) + amt);
    end else if (o == OP_INVERT) begin
        res = {3{clamp_ch(`IMG_PIX_MAX - g)}};
    end else if (g > int'(a.thresh.level)) begin
        res = {3{clamp_ch(`IMG_PIX_MAX)}};  // brighter than level
    end else begin
        res = '0;
    end
    return res;
endfunction

// one channel of blur or edge magnitude
function automatic chan_t tap_ch(int l, int c, int r, op_e o);
    if (o == OP_EDGE) begin
        return clamp_ch((r > l) ? r - l : l - r);
    end
    return clamp_ch((l + c + r) / 3);
endfunction

function automatic rgb_t tap_ref(rgb_t l, rgb_t c, rgb_t r, op_e o);
    rgb_t res;
    res.red   = tap_ch(int'(l.red), int'(c.red), int'(r.red), o);
    res.green = tap_ch(int'(l.green), int'(c.green), int'(r.green), o);
    res.blue  = tap_ch(int'(l.blue), int'(c.blue), int'(r.blue), o);
    return res;
endfunction

// pushes the expected beats of line_px[0 .. 2*pairs-1]
function automatic void expect_line(int pairs, op_e o, op_arg_u a);
    int        i;
    int        last;
    rgb_t      l;
    rgb_t      r;
    rgb_t      res;
    pix_beat_t b;
    last = 2 * pairs - 1;
    b    = '0;
    for (i = 0; i <= last; i++) begin
        l = (i == 0) ? line_px[i] : line_px[i-1];      // replicate at line start
        r = (i == last) ? line_px[i] : line_px[i+1];   // and at line end
        if (o == OP_BLUR || o == OP_EDGE) begin
            res = tap_ref(l, line_px[i], r, o);
        end else begin
            res = point_ref(line_px[i], o, a);
        end
        if (i % 2 == 0) begin
            b.pair.p0 = res;
        end else begin
            b.pair.p1 = res;
            b.eol     = (i == last);
            exp_q.push_back(b);
        end
    end
endfunction

`endif

// ==== dv/pix_filter_tb.sv ====
// directed tests for pix_filter_top against the line model
// op and arg only change once the output has drained

`timescale 1ns/1ps
`default_nettype none

module pix_filter_tb;

    import img_pkg::*;

    `include "pix_filter_model.svh"

    logic        clk = 1'b0;
    logic        rst_n;
    op_e         op;
    op_arg_u     arg;
    pix_beat_t   in_beat;
    logic        in_valid;
    logic        in_ready;
    pix_beat_t   out_beat;
    logic        out_valid;
    logic        out_ready = 1'b1;
    logic        bp_en = 1'b0;        // random back-pressure on out_ready
    logic        in_fire = 1'b0;      // input transfer at the last rising edge
    logic [31:0] bp_rnd;
    integer      seed;
    int          errors;
    int          sent_count;
    int          recv_count;
    pix_beat_t   exp_beat;

    pix_filter_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .op        (op),
        .arg       (arg),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #4 clk = ~clk;

    always @(posedge clk) in_fire <= in_valid && in_ready;

    always @(negedge clk) begin
        if (bp_en) begin
            bp_rnd    = $random(seed);
            out_ready = bp_rnd[0];
        end else begin
            out_ready = 1'b1;
        end
    end

    // compares output beats in arrival order
    always @(posedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            recv_count++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("error: %0d ns output beat %h arrived with none expected", $time,
                    out_beat);
            end else begin
                exp_beat = exp_q.pop_front();
                if (out_beat.pair !== exp_beat.pair) begin
                    errors++;
                    $display("error: %0d ns pair %h, expected %h", $time, out_beat.pair,
                        exp_beat.pair);
                end
                if (out_beat.eol !== exp_beat.eol) begin
                    errors++;
                    $display("error: %0d ns eol %b, expected %b", $time, out_beat.eol,
                        exp_beat.eol);
                end
            end
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("beats sent %0d, received %0d, errors %0d", sent_count, recv_count, errors);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic set_op(input op_e o, input logic [7:0] a);
        op  = o;
        arg = op_arg_u'(a);
    endtask

    // called right after a falling edge
    task automatic drive_beat(input pix_beat_t b);
        int waited;
        waited   = 0;
        in_beat  = b;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_fire) begin
            if (waited >= `TB_WAIT_LIMIT) begin
                abort_run("timeout: the filter never accepted an input beat");
            end
            waited++;
            @(negedge clk);
        end
        sent_count++;
    endtask

    task automatic send_line(input int pairs);
        int        k;
        pix_beat_t b;
        expect_line(pairs, op, arg);
        for (k = 0; k < pairs; k++) begin
            b.pair.p0 = line_px[2*k];
            b.pair.p1 = line_px[2*k+1];
            b.eol     = (k == pairs - 1);
            drive_beat(b);
        end
        in_valid = 1'b0;   // next line may follow in the same step
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited >= `TB_WAIT_LIMIT) begin
                abort_run($sformatf("timeout: %0d expected beats never came out",
                    exp_q.size()));
            end
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic pick_length(output int n);
        logic [31:0] rnd;
        rnd = $random(seed);
        n   = 1 + int'(rnd % 6);
    endtask

    task automatic fill_random(input int pairs);
        int          i;
        logic [31:0] rnd;
        for (i = 0; i < 2 * pairs; i++) begin
            rnd        = $random(seed);
            line_px[i] = rnd[23:0];
        end
    endtask

    // empty window and output register right after reset
    task automatic check_reset_outputs();
        if (in_ready !== 1'b1 || out_valid !== 1'b0) begin
            errors++;
            $display("error: %0d ns after reset in_ready %b out_valid %b, expected 1 and 0",
                $time, in_ready, out_valid);
        end
    endtask

    task automatic invert_random_lines();
        int n;
        set_op(OP_INVERT, 8'h00);
        repeat (3) begin
            pick_length(n);
            fill_random(n);
            send_line(n);
        end
        wait_drain();
    endtask

    task automatic brightness_saturation();
        set_op(OP_BRIGHT, {1'b0, 7'd100});
        line_px[0] = {8'd200, 8'd50, 8'd200};   // 200 saturates and 50 goes to 150
        line_px[1] = {8'd50, 8'd200, 8'd50};
        line_px[2] = {8'd200, 8'd200, 8'd200};
        line_px[3] = {8'd50, 8'd50, 8'd50};
        send_line(2);
        wait_drain();
        set_op(OP_BRIGHT, {1'b1, 7'd100});
        line_px[0] = {8'd60, 8'd60, 8'd60};
        line_px[1] = {8'd60, 8'd160, 8'd100};
        send_line(1);
        wait_drain();
    endtask

    task automatic threshold_around_level();
        set_op(OP_THRESH, 8'd90);
        line_px[0] = {8'd91, 8'd91, 8'd91};     // gray 91
        line_px[1] = {8'd90, 8'd92, 8'd91};     // gray 91
        line_px[2] = {8'd90, 8'd90, 8'd90};     // gray 90
        line_px[3] = {8'd92, 8'd90, 8'd89};     // gray 90
        line_px[4] = {8'd255, 8'd10, 8'd8};     // gray 91
        line_px[5] = {8'd0, 8'd0, 8'd0};
        send_line(3);
        wait_drain();
    endtask

    // 1, 2 and 5 pair lines back to back
    task automatic blur_mixed_lines();
        set_op(OP_BLUR, 8'h00);
        fill_random(1);
        send_line(1);
        fill_random(2);
        send_line(2);
        fill_random(5);
        send_line(5);
        wait_drain();
    endtask

    task automatic edge_ramp_and_step();
        int i;
        set_op(OP_EDGE, 8'h00);
        for (i = 0; i < 8; i++) begin
            line_px[i] = {chan_t'(i * 30), chan_t'(i * 10), chan_t'(240 - i * 30)};
        end
        send_line(4);
        for (i = 0; i < 8; i++) begin
            if (i < 4) begin
                line_px[i] = {8'd10, 8'd20, 8'd30};
            end else begin
                line_px[i] = {8'd200, 8'd180, 8'd160};
            end
        end
        send_line(4);
        wait_drain();
    endtask

    task automatic backpressure_stream();
        int n;
        int base_sent;
        int base_recv;
        set_op(OP_BLUR, 8'h00);
        base_sent = sent_count;
        base_recv = recv_count;
        bp_en     = 1'b1;
        repeat (4) begin
            pick_length(n);
            fill_random(n);
            send_line(n);
        end
        wait_drain();
        bp_en = 1'b0;
        if (recv_count - base_recv != sent_count - base_sent) begin
            errors++;
            $display("error: %0d ns received %0d beats under back-pressure, sent %0d", $time,
                recv_count - base_recv, sent_count - base_sent);
        end
    endtask

    initial begin
        seed       = 52317;
        errors     = 0;
        sent_count = 0;
        recv_count = 0;
        rst_n      = 1'b0;
        op         = OP_BRIGHT;
        arg        = '0;
        in_beat    = '0;
        in_valid   = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_reset_outputs();
        invert_random_lines();
        brightness_saturation();
        threshold_around_level();
        blur_mixed_lines();
        edge_ramp_and_step();
        backpressure_stream();
        repeat (4) @(negedge clk);   // catch any stray output beat
        $display("beats sent %0d, received %0d, errors %0d", sent_count, recv_count, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/img_params.svh ====
// channel format for the pixel filter, 8-bit rgb only
// the gray divisor is tied to the three-channel average

`ifndef IMG_PARAMS_SVH
`define IMG_PARAMS_SVH

// bits per colour channel
`define IMG_PIX_W 8

// full-scale channel value, saturation ceiling
`define IMG_PIX_MAX 255

// averaging divisor for gray level and 3-tap blur
`define IMG_GRAY_DIV 3

`endif

// ==== hdl/img_pkg.sv ====
// stream and window types for the pixel filter
// a beat is two adjacent pixels, p0 on the left

`include "img_params.svh"

`default_nettype none

package img_pkg;

    typedef logic [`IMG_PIX_W-1:0] chan_t;

    typedef struct packed {
        chan_t red;
        chan_t green;
        chan_t blue;
    } rgb_t;

    typedef struct packed {
        rgb_t p0;   // left pixel
        rgb_t p1;
    } pix_pair_t;

    typedef struct packed {
        pix_pair_t pair;
        logic      eol;     // last pair of the line
    } pix_beat_t;

    // centre pair with one neighbour on each side
    typedef struct packed {
        rgb_t      left;
        pix_pair_t pair;
        rgb_t      right;
        logic      eol;
    } pix_win_t;

    typedef enum logic [2:0] {
        OP_BRIGHT = 3'd0,
        OP_INVERT = 3'd1,
        OP_THRESH = 3'd2,
        OP_BLUR   = 3'd3,
        OP_EDGE   = 3'd4
    } op_e;

    typedef struct packed {
        logic       darken;     // subtract instead of add
        logic [6:0] amount;
    } bright_arg_t;

    typedef struct packed {
        chan_t level;
    } thresh_arg_t;

    // one argument byte, read by brightness or by threshold
    typedef union packed {
        bright_arg_t bright;
        thresh_arg_t thresh;
    } op_arg_u;

    // floor of the mean of three channels, never above full scale
    function automatic chan_t avg3(chan_t a, chan_t b, chan_t c);
        logic [`IMG_PIX_W+1:0] sum;
        sum = a + b + c;
        return chan_t'(sum / `IMG_GRAY_DIV);
    endfunction

endpackage

`default_nettype wire

// ==== hdl/neighbor_unit.sv ====
// 3-tap horizontal ops on the centre pair, purely combinational
// neighbours come in already replicated at line ends

`timescale 1ns/1ps
`default_nettype none

module neighbor_unit (
    input  wire img_pkg::pix_win_t win,
    input  wire img_pkg::op_e      op,
    output img_pkg::pix_pair_t     result
);

    import img_pkg::*;

    function automatic chan_t abs_diff(chan_t a, chan_t b);
        if (a > b) begin
            return a - b;
        end
        return b - a;
    endfunction

    // edge magnitude or blur for one centre pixel
    function automatic rgb_t tap3(rgb_t l, rgb_t c, rgb_t r, op_e sel);
        rgb_t res;
        if (sel == OP_EDGE) begin
            res.red   = abs_diff(r.red, l.red);     // centre tap unused
            res.green = abs_diff(r.green, l.green);
            res.blue  = abs_diff(r.blue, l.blue);
        end else begin
            res.red   = avg3(l.red, c.red, r.red);
            res.green = avg3(l.green, c.green, r.green);
            res.blue  = avg3(l.blue, c.blue, r.blue);
        end
        return res;
    endfunction

    always_comb begin
        // p0 sits between left and p1, p1 between p0 and right
        result.p0 = tap3(win.left, win.pair.p0, win.pair.p1, op);
        result.p1 = tap3(win.pair.p0, win.pair.p1, win.right, op);
    end

endmodule

`default_nettype wire

// ==== hdl/pix_filter_top.sv ====
// streaming rgb filter, two pixels per beat, lines delimited by eol
// op and arg must stay stable while any beat is inside

`timescale 1ns/1ps
`default_nettype none

module pix_filter_top (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire img_pkg::op_e       op,
    input  wire img_pkg::op_arg_u   arg,
    input  wire img_pkg::pix_beat_t in_beat,
    input  wire                     in_valid,
    output logic                    in_ready,
    output img_pkg::pix_beat_t      out_beat,
    output logic                    out_valid,
    input  wire                     out_ready
);

    import img_pkg::*;

    pix_win_t  win;
    logic      win_valid;
    logic      win_ready;
    pix_pair_t point_res;
    pix_pair_t neigh_res;

    pix_window u_window (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .win       (win),
        .win_valid (win_valid),
        .win_ready (win_ready)
    );

    // both units see the same window
    point_unit u_point (
        .win    (win),
        .op     (op),
        .arg    (arg),
        .result (point_res)
    );

    neighbor_unit u_neighbor (
        .win    (win),
        .op     (op),
        .result (neigh_res)
    );

    result_merge u_merge (
        .clk       (clk),
        .rst_n     (rst_n),
        .op        (op),
        .point_res (point_res),
        .neigh_res (neigh_res),
        .eol       (win.eol),
        .win_valid (win_valid),
        .win_ready (win_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

// ==== hdl/pix_window.sv ====
// one-pair window with neighbour replication at line ends
// a non-eol pair is presented together with the next input beat

`timescale 1ns/1ps
`default_nettype none

module pix_window (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire img_pkg::pix_beat_t in_beat,
    input  wire                   in_valid,
    output logic                  in_ready,
    output img_pkg::pix_win_t     win,
    output logic                  win_valid,
    input  wire                   win_ready
);

    import img_pkg::*;

    pix_beat_t hold_beat;       // pair waiting for its right neighbour
    rgb_t      hold_left;       // left neighbour of the held p0
    logic      hold_valid;
    logic      line_start;      // next accepted pair opens a line
    logic      give_win;
    logic      take_in;

    // eol pair already knows its right side, others need the next p0
    assign win_valid = hold_valid && (hold_beat.eol || in_valid);
    assign give_win  = win_valid && win_ready;

    // a held non-eol pair only leaves when its successor comes in
    assign in_ready = !hold_valid || give_win;
    assign take_in  = in_valid && in_ready;

    always_comb begin
        win.left = hold_left;
        win.pair = hold_beat.pair;
        win.eol  = hold_beat.eol;
        if (hold_beat.eol) begin
            win.right = hold_beat.pair.p1;     // replicate at line end
        end else begin
            win.right = in_beat.pair.p0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
            line_start <= 1'b1;
        end else begin
            if (take_in) begin
                hold_valid <= 1'b1;
                line_start <= in_beat.eol;
            end else if (give_win) begin
                hold_valid <= 1'b0;
            end
        end
    end

    // payload only, qualified by hold_valid
    always_ff @(posedge clk) begin
        if (take_in) begin
            hold_beat <= in_beat;
            if (line_start) begin
                hold_left <= in_beat.pair.p0;   // first pair of a line
            end else begin
                // previous pair of the line is leaving this cycle
                hold_left <= hold_beat.pair.p1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/point_unit.sv ====
// per-pixel operations on the centre pair, purely combinational
// brightness amount is limited to 7 bits by the argument format

`timescale 1ns/1ps
`default_nettype none

`include "img_params.svh"

module point_unit (
    input  wire img_pkg::pix_win_t win,
    input  wire img_pkg::op_e      op,
    input  wire img_pkg::op_arg_u  arg,
    output img_pkg::pix_pair_t     result
);

    import img_pkg::*;

    // add or subtract with saturation at both ends
    function automatic chan_t sat_adjust(chan_t c, logic darken, logic [6:0] amount);
        logic [`IMG_PIX_W:0] wide;     // extra bit catches carry or borrow
        if (darken) begin
            wide = {1'b0, c} - {1'b0, chan_t'(amount)};
            return wide[`IMG_PIX_W] ? chan_t'(0) : wide[`IMG_PIX_W-1:0];
        end
        wide = {1'b0, c} + {1'b0, chan_t'(amount)};
        return wide[`IMG_PIX_W] ? chan_t'(`IMG_PIX_MAX) : wide[`IMG_PIX_W-1:0];
    endfunction

    function automatic rgb_t point_pix(rgb_t px, op_e sel, op_arg_u a);
        chan_t gray;
        rgb_t  res;
        gray = avg3(px.red, px.green, px.blue);
        case (sel)
            OP_BRIGHT: begin
                res.red   = sat_adjust(px.red, a.bright.darken, a.bright.amount);
                res.green = sat_adjust(px.green, a.bright.darken, a.bright.amount);
                res.blue  = sat_adjust(px.blue, a.bright.darken, a.bright.amount);
            end
            OP_INVERT: begin
                res = {3{chan_t'(`IMG_PIX_MAX - gray)}};
            end
            OP_THRESH: begin
                if (gray > a.thresh.level) begin
                    res = {3{chan_t'(`IMG_PIX_MAX)}};
                end else begin
                    res = '0;
                end
            end
            default: begin
                res = px;   // neighbour ops, not selected downstream
            end
        endcase
        return res;
    endfunction

    always_comb begin
        result.p0 = point_pix(win.pair.p0, op, arg);
        result.p1 = point_pix(win.pair.p1, op, arg);
    end

endmodule

`default_nettype wire

// ==== hdl/result_merge.sv ====
// picks point or neighbour result and registers it into the output stage
// single output register, full throughput while out_ready stays high

`timescale 1ns/1ps
`default_nettype none

module result_merge (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire img_pkg::op_e       op,
    input  wire img_pkg::pix_pair_t point_res,
    input  wire img_pkg::pix_pair_t neigh_res,
    input  wire                     eol,
    input  wire                     win_valid,
    output logic                    win_ready,
    output img_pkg::pix_beat_t      out_beat,
    output logic                    out_valid,
    input  wire                     out_ready
);

    import img_pkg::*;

    pix_pair_t sel_res;
    logic      take_win;

    always_comb begin
        if (op == OP_BLUR || op == OP_EDGE) begin
            sel_res = neigh_res;
        end else begin
            sel_res = point_res;
        end
    end

    // register free now or emptied this cycle
    assign win_ready = !out_valid || out_ready;
    assign take_win  = win_valid && win_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (win_ready) begin
            out_valid <= win_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take_win) begin
            out_beat.pair <= sel_res;
            out_beat.eol  <= eol;   // line marker follows its pair
        end
    end

endmodule

`default_nettype wire

// ==== pix_filter.f ====
+incdir+hdl
+incdir+dv
hdl/img_pkg.sv
hdl/pix_window.sv
hdl/point_unit.sv
hdl/neighbor_unit.sv
hdl/result_merge.sv
hdl/pix_filter_top.sv
dv/pix_filter_tb.sv

// ==== run.sh ====
#!/bin/sh
# compiles the pixel filter testbench with verilator and runs it
# exit status is nonzero unless the pass line shows up in the output

verilator --binary --timing -Wno-fatal \
    --top-module pix_filter_tb \
    -f pix_filter.f \
    -o pix_filter_sim &&
./obj_dir/pix_filter_sim | tee /dev/stderr | grep -qx "Finished with no errors" &&
echo "simulation passed" ||
{
    echo "simulation failed"
    exit 1
}
